// File: hdl/display_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module display_sequencer (
	input logic clk,
	input logic rst_n,
	input logic snap_valid,
	input photon_pkg::bcd_count_t snap_count,
	output logic cmd_en,
	output photon_pkg::oled_cmd_t cmd,
	input logic cmd_done
);
	import photon_pkg::*;

	oled_op_t stage; // init, clear, then draw for good.
	logic frame_active; // eight draws in flight.
	logic [2:0] pos; // digit slot, 0 leftmost.
	logic pending; // snapshot waiting for a frame.
	logic take; // frame starts this cycle.
	bcd_count_t latest; // newest unshown snapshot.
	bcd_count_t frame; // digits of the frame being drawn.

	assign take = (stage == DRAW) && !frame_active && (snap_valid || pending);

	// snapshot data.
	always_ff @(posedge clk) begin
		if (snap_valid) latest <= snap_count; // older ones dropped.
		if (take) frame <= snap_valid ? snap_count : latest;
	end

	////////////////////////////////////////
	// step control.
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stage <= INIT;
			cmd_en <= 1'b0;
			cmd <= '0;
			frame_active <= 1'b0;
			pos <= 3'd0;
			pending <= 1'b0;
		end else begin
			if (take) pending <= 1'b0;
			else if (snap_valid && stage == DRAW) pending <= 1'b1; // mid frame.
			case (stage)
				INIT, CLEAR: begin
					if (cmd_done) begin
						cmd_en <= 1'b0;
						stage <= (stage == INIT) ? CLEAR : DRAW;
					end else if (!cmd_en) begin
						cmd_en <= 1'b1;
						cmd <= '{op: stage, col: 7'd0, page: 3'd0, digit: 4'd0};
					end
				end
				default: begin
					if (take) begin
						frame_active <= 1'b1;
						pos <= 3'd0; // most significant digit first.
					end else if (frame_active) begin
						if (cmd_done) begin
							cmd_en <= 1'b0;
							if (pos == 3'(NUM_DIGITS - 1)) frame_active <= 1'b0;
							else pos <= pos + 3'd1;
						end else if (!cmd_en) begin
							cmd_en <= 1'b1;
							cmd <= '{op: DRAW, col: 7'(pos * GLYPH_W), page: DIGIT_PAGE,
								digit: frame[3'(NUM_DIGITS - 1) - pos]};
						end
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/gate_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module gate_ctrl (
	input logic clk,
	input logic rst_n,
	input logic cfg_wr,
	input logic [photon_pkg::GATE_W-1:0] cfg_gate_len,
	input photon_pkg::bcd_count_t count,
	output logic gate_end,
	output logic snap_valid,
	output photon_pkg::bcd_count_t snap_count
);
	import photon_pkg::*;

	logic [GATE_W-1:0] gate_len; // window length in clk cycles.
	logic [GATE_W-1:0] timer; // cycles into the window.

	////////////////////////////////////////
	// gate length register and timer.
	////////////////////////////////////////
	assign gate_end = (timer == gate_len - 1'b1); // last cycle of the window.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			gate_len <= GATE_W'(GATE_DEFAULT);
			timer <= '0;
		end else if (cfg_wr) begin
			gate_len <= cfg_gate_len; // new length,
			timer <= '0; // window restarts.
		end else if (gate_end) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	////////////////////////////////////////
	// snapshot.
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			snap_valid <= 1'b0;
			snap_count <= '0;
		end else begin
			snap_valid <= gate_end; // lines up with the new snapshot.
			if (gate_end) snap_count <= count; // held till next window end.
		end
	end

endmodule

`default_nettype wire

// File: hdl/glyph_rom.sv
`timescale 1ns/100ps
`default_nettype none

module glyph_rom (
	input logic [3:0] digit,
	input logic [2:0] col,
	output logic [7:0] glyph_byte
);
	import photon_pkg::*;

	// column 0 leftmost, bit 0 is the top pixel row.
	logic [0:GLYPH_W-1][7:0] glyph;

	always_comb begin
		case (digit)
			4'd0: glyph = {8'h00, 8'h3E, 8'h51, 8'h49, 8'h45, 8'h3E, 8'h00, 8'h00};
			4'd1: glyph = {8'h00, 8'h00, 8'h42, 8'h7F, 8'h40, 8'h00, 8'h00, 8'h00};
			4'd2: glyph = {8'h00, 8'h42, 8'h61, 8'h51, 8'h49, 8'h46, 8'h00, 8'h00};
			4'd3: glyph = {8'h00, 8'h21, 8'h41, 8'h45, 8'h4B, 8'h31, 8'h00, 8'h00};
			4'd4: glyph = {8'h00, 8'h18, 8'h14, 8'h12, 8'h7F, 8'h10, 8'h00, 8'h00};
			4'd5: glyph = {8'h00, 8'h27, 8'h45, 8'h45, 8'h45, 8'h39, 8'h00, 8'h00};
			4'd6: glyph = {8'h00, 8'h3C, 8'h4A, 8'h49, 8'h49, 8'h30, 8'h00, 8'h00};
			4'd7: glyph = {8'h00, 8'h01, 8'h71, 8'h09, 8'h05, 8'h03, 8'h00, 8'h00};
			4'd8: glyph = {8'h00, 8'h36, 8'h49, 8'h49, 8'h49, 8'h36, 8'h00, 8'h00};
			4'd9: glyph = {8'h00, 8'h06, 8'h49, 8'h49, 8'h29, 8'h1E, 8'h00, 8'h00};
			default: glyph = '0; // 10..15 blank.
		endcase
	end

	assign glyph_byte = glyph[col]; // one column per read.

endmodule

`default_nettype wire

// File: hdl/oled_spi_driver.sv
`timescale 1ns/100ps
`default_nettype none
`include "oled_init.svh"

module oled_spi_driver (
	input logic clk,
	input logic rst_n,
	input logic cmd_en,
	input photon_pkg::oled_cmd_t cmd,
	output logic cmd_done,
	output logic [3:0] glyph_digit,
	output logic [2:0] glyph_col,
	input logic [7:0] glyph_byte,
	output logic cs_n,
	output logic sclk,
	output logic dc,
	output logic sdin
);
	import photon_pkg::*;

	logic busy;
	logic start;
	logic bit_end; // last clk of a bit time.
	logic [$clog2(SCLK_DIV)-1:0] div; // position in the bit time.
	logic [2:0] bit_cnt;
	logic [10:0] byte_cnt; // byte being shifted, up to 3 + 1024.
	logic [10:0] next_idx; // byte to load next.
	logic [10:0] last_idx; // final byte of this command.
	logic [7:0] shift;
	logic [7:0] src_byte;
	logic src_dc;

	assign start = cmd_en && !busy && !cmd_done; // en still high in done cycle.
	assign bit_end = busy && (int'(div) == SCLK_DIV - 1);
	assign next_idx = busy ? byte_cnt + 11'd1 : 11'd0;
	assign sdin = shift[7]; // msb first.

	////////////////////////////////////////
	// byte source.
	////////////////////////////////////////
	assign glyph_digit = cmd.digit;
	assign glyph_col = 3'(next_idx - 11'd3); // data bytes follow 3 address bytes.

	always_comb begin
		case (cmd.op)
			INIT: last_idx = 11'(`OLED_INIT_LEN - 1);
			CLEAR: last_idx = 11'(CLEAR_BYTES + 2);
			default: last_idx = 11'(GLYPH_W + 2);
		endcase
	end

	always_comb begin
		src_byte = 8'h00;
		src_dc = 1'b0;
		if (cmd.op == INIT) begin
			src_byte = `OLED_INIT_BYTE(next_idx);
		end else begin
			case (next_idx)
				11'd0: src_byte = {4'h0, cmd.col[3:0]}; // column low nibble.
				11'd1: src_byte = {5'b00010, cmd.col[6:4]}; // column high nibble.
				11'd2: src_byte = {5'b10110, cmd.page}; // page start.
				default: begin
					src_dc = 1'b1; // gram data.
					src_byte = (cmd.op == DRAW) ? glyph_byte : 8'h00;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// serializer.
	////////////////////////////////////////
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			div <= '0;
			bit_cnt <= 3'd0;
			byte_cnt <= 11'd0;
			shift <= 8'h00;
			cs_n <= 1'b1;
			sclk <= 1'b0;
			dc <= 1'b0;
			cmd_done <= 1'b0;
		end else begin
			cmd_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cs_n <= 1'b0; // low for the whole command.
				div <= '0;
				bit_cnt <= 3'd0;
				byte_cnt <= 11'd0;
				shift <= src_byte;
				dc <= src_dc;
			end else if (busy) begin
				div <= bit_end ? '0 : div + 1'b1;
				if (int'(div) == SCLK_DIV / 2 - 1) sclk <= 1'b1; // rising mid bit.
				if (bit_end) begin
					sclk <= 1'b0; // falling edge, data moves.
					bit_cnt <= bit_cnt + 3'd1;
					if (bit_cnt != 3'd7) begin
						shift <= {shift[6:0], 1'b0};
					end else if (byte_cnt == last_idx) begin
						busy <= 1'b0;
						cs_n <= 1'b1;
						dc <= 1'b0;
						shift <= 8'h00;
						cmd_done <= 1'b1;
					end else begin
						byte_cnt <= next_idx; // next byte back to back.
						shift <= src_byte;
						dc <= src_dc;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/photon_counter_top.sv
`timescale 1ns/100ps
`default_nettype none

module photon_counter_top (
	input logic clk,
	input logic rst_n,
	input logic pulse, // detector output, async.
	input logic cfg_wr,
	input logic [photon_pkg::GATE_W-1:0] cfg_gate_len,
	output logic snap_valid,
	output photon_pkg::bcd_count_t snap_count,
	output logic cs_n,
	output logic sclk,
	output logic dc,
	output logic sdin
);
	import photon_pkg::*;

	bcd_count_t count; // live count.
	logic gate_end;
	logic cmd_en;
	logic cmd_done;
	oled_cmd_t cmd;
	logic [3:0] glyph_digit;
	logic [2:0] glyph_col;
	logic [7:0] glyph_byte;

	////////////////////////////////////////
	// counting.
	////////////////////////////////////////
	pulse_counter u_pulse_counter (
		.clk(clk),
		.rst_n(rst_n),
		.pulse(pulse),
		.clear(gate_end), // window end clears.
		.count(count)
	);

	gate_ctrl u_gate_ctrl (
		.clk(clk),
		.rst_n(rst_n),
		.cfg_wr(cfg_wr),
		.cfg_gate_len(cfg_gate_len),
		.count(count),
		.gate_end(gate_end),
		.snap_valid(snap_valid),
		.snap_count(snap_count)
	);

	////////////////////////////////////////
	// display.
	////////////////////////////////////////
	display_sequencer u_display_sequencer (
		.clk(clk),
		.rst_n(rst_n),
		.snap_valid(snap_valid),
		.snap_count(snap_count),
		.cmd_en(cmd_en),
		.cmd(cmd),
		.cmd_done(cmd_done)
	);

	oled_spi_driver u_oled_spi_driver (
		.clk(clk),
		.rst_n(rst_n),
		.cmd_en(cmd_en),
		.cmd(cmd),
		.cmd_done(cmd_done),
		.glyph_digit(glyph_digit),
		.glyph_col(glyph_col),
		.glyph_byte(glyph_byte),
		.cs_n(cs_n),
		.sclk(sclk),
		.dc(dc),
		.sdin(sdin)
	);

	glyph_rom u_glyph_rom (
		.digit(glyph_digit),
		.col(glyph_col),
		.glyph_byte(glyph_byte) // read back the same cycle.
	);

endmodule

`default_nettype wire

// File: hdl/photon_pkg.sv
`default_nettype none

package photon_pkg;

	////////////////////////////////////////
	// pulse count.
	////////////////////////////////////////
	localparam int NUM_DIGITS = 8; // eight bcd digits on one row.

	// digit 0 is the least significant.
	typedef logic [NUM_DIGITS-1:0][3:0] bcd_count_t;

	////////////////////////////////////////
	// gate window.
	////////////////////////////////////////
	localparam int GATE_W = 24; // gate length width.
	localparam int GATE_DEFAULT = 20000; // 400 us at 50 mhz.

	////////////////////////////////////////
	// oled link.
	////////////////////////////////////////
	localparam int SCLK_DIV = 4; // clk cycles per spi bit, even.
	localparam logic [2:0] DIGIT_PAGE = 3'd2; // row of the digits.
	localparam int GLYPH_W = 8; // columns per glyph.
	localparam int CLEAR_BYTES = 1024; // 128 columns x 8 pages.

	// what the driver does for one command.
	typedef enum logic [1:0] {
		INIT,
		CLEAR,
		DRAW
	} oled_op_t;

	typedef struct packed {
		oled_op_t op;
		logic [6:0] col; // start column.
		logic [2:0] page; // start page.
		logic [3:0] digit; // glyph code, draw only.
	} oled_cmd_t;

endpackage

`default_nettype wire

// File: hdl/pulse_counter.sv
`timescale 1ns/100ps
`default_nettype none

module pulse_counter (
	input logic clk,
	input logic rst_n,
	input logic pulse,
	input logic clear,
	output photon_pkg::bcd_count_t count
);
	import photon_pkg::*;

	logic sync_0; // first synchronizer stage.
	logic sync_1; // second stage, safe to use.
	logic pulse_q; // edge register.
	logic rise;
	logic carry;
	bcd_count_t count_nxt;

	assign rise = sync_1 & ~pulse_q; // one cycle per rising edge.

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_0 <= 1'b0;
			sync_1 <= 1'b0;
			pulse_q <= 1'b0;
		end else begin
			sync_0 <= pulse;
			sync_1 <= sync_0;
			pulse_q <= sync_1;
		end
	end

	// clear wins over the held count, an edge in the clear cycle opens the new window.
	always_comb begin
		carry = rise;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			count_nxt[i] = clear ? 4'd0 : count[i];
			if (carry) begin
				if (count_nxt[i] == 4'd9) begin
					count_nxt[i] = 4'd0; // roll, carry on.
				end else begin
					count_nxt[i] = count_nxt[i] + 4'd1;
					carry = 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) count <= '0;
		else count <= count_nxt; // wraps past 99999999.
	end

endmodule

`default_nettype wire

// File: include/oled_init.svh
`ifndef OLED_INIT_SVH
`define OLED_INIT_SVH

// ssd1306 power-up list, sent with dc low.
// clock divide, multiplex and offset stay at their power-on values.
`define OLED_INIT_LEN 10

// byte n of the list.
`define OLED_INIT_BYTE(n) ( \
	((n) == 0) ? 8'hAE : \
	((n) == 1) ? 8'h8D : \
	((n) == 2) ? 8'h14 : \
	((n) == 3) ? 8'h20 : \
	((n) == 4) ? 8'h00 : \
	((n) == 5) ? 8'hA1 : \
	((n) == 6) ? 8'hC8 : \
	((n) == 7) ? 8'h81 : \
	((n) == 8) ? 8'hCF : \
	8'hAF)

`endif

// File: project.f
+incdir+include
hdl/photon_pkg.sv
hdl/pulse_counter.sv
hdl/gate_ctrl.sv
hdl/glyph_rom.sv
hdl/display_sequencer.sv
hdl/oled_spi_driver.sv
hdl/photon_counter_top.sv
tests/tb_photon_counter.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the photon counter testbench with verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_photon_counter \
	-f project.f --Mdir "$BUILD" -o tb_photon_counter
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD/tb_photon_counter" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "No errors" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: tests/tb_photon_counter.sv
`timescale 1ns/100ps
`default_nettype none
`include "oled_init.svh"

module tb_photon_counter;
	import photon_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYC = 16;
	localparam int GATE_A = 6000; // first programmed window.
	localparam int GATE_B = 5000; // second one.
	localparam int BYTE_CYC = 8 * SCLK_DIV;
	localparam int FRAME_CYC = NUM_DIGITS * (3 + GLYPH_W) * BYTE_CYC;
	localparam int FRAMES = 6; // one per snapshot after the clear.
	localparam int BUS_BYTES = `OLED_INIT_LEN + 3 + CLEAR_BYTES
		+ FRAMES * NUM_DIGITS * (3 + GLYPH_W); // init, clear and all frames.
	localparam int WD_CYCLES = (RESET_CYC + (`OLED_INIT_LEN + 3 + CLEAR_BYTES) * BYTE_CYC
		+ 5 * GATE_A + GATE_B + FRAME_CYC + 200) * 3 / 2;

	logic clk;
	logic rst_n;
	logic pulse;
	logic cfg_wr;
	logic [GATE_W-1:0] cfg_gate_len;
	logic snap_valid;
	bcd_count_t snap_count;
	logic cs_n;
	logic sclk;
	logic dc;
	logic sdin;

	int seed = 70;
	int model_edges = 0; // rising edges driven so far.
	int edges_base = 0; // model_edges at the last snapshot.
	int cyc = 0;
	int wr_cyc = 0;
	int last_snap = 0;
	int exp_len = GATE_DEFAULT;
	logic after_wr = 1'b0;
	logic snap_seen = 1'b0;
	logic [9:0] bus_q[$]; // {first of command, dc, byte}.
	int rd_ptr = 0;
	int nbits = 0;
	logic [7:0] shreg = 8'h00;
	logic first_flag = 1'b1;
	logic clear_done = 1'b0;
	int frames_seen = 0;

	photon_counter_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.pulse(pulse),
		.cfg_wr(cfg_wr),
		.cfg_gate_len(cfg_gate_len),
		.snap_valid(snap_valid),
		.snap_count(snap_count),
		.cs_n(cs_n),
		.sclk(sclk),
		.dc(dc),
		.sdin(sdin)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////////////////////////
	// checking helpers.
	////////////////////////////////////////
	task automatic expect_equal(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (expected === actual) else begin
			$display("ERR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
			$display("Errors found");
			$fatal(1);
		end
	endtask

	// decimal to eight bcd digits with digit 0 lowest.
	function automatic bcd_count_t to_bcd(input int value);
		bcd_count_t d;
		int v;
		v = value;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			d[i] = 4'(v % 10);
			v = v / 10;
		end
		return d;
	endfunction

	task automatic check_idle();
		expect_equal("cs_n", 32'(1), 32'(cs_n));
		expect_equal("sclk", 32'(0), 32'(sclk));
		expect_equal("snap_valid", 32'(0), 32'(snap_valid));
	endtask

	////////////////////////////////////////
	// stimulus helpers.
	////////////////////////////////////////
	task automatic hold(input int cycles);
		repeat (cycles) @(posedge clk);
		#10; // inputs move just after the edge.
	endtask

	task automatic wait_snap();
		do begin
			@(negedge clk);
		end while (!snap_valid);
		@(posedge clk);
		#10;
	endtask

	task automatic write_gate(input int len);
		cfg_gate_len = GATE_W'(len);
		cfg_wr = 1'b1;
		hold(1);
		cfg_wr = 1'b0;
	endtask

	// random pulse train that stops well before the window ends.
	task automatic drive_burst(input int limit);
		int n;
		int h;
		int g;
		int used;
		n = {$random(seed)} % 301;
		used = 0;
		for (int i = 0; i < n; i++) begin
			h = 2 + {$random(seed)} % 8;
			g = 2 + {$random(seed)} % 8;
			if (used + h + g > limit) break;
			pulse = 1'b1;
			model_edges = model_edges + 1;
			hold(h);
			pulse = 1'b0;
			hold(g);
			used = used + h + g;
		end
	endtask

	////////////////////////////////////////
	// snapshot and gate timing monitor.
	////////////////////////////////////////
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (cfg_wr) begin
			wr_cyc = cyc;
			exp_len = int'(cfg_gate_len);
			after_wr = 1'b1;
		end
		if (snap_valid) begin
			expect_equal("snap_count", to_bcd(model_edges - edges_base), snap_count);
			edges_base = model_edges;
			if (after_wr) expect_equal("snap_valid after cfg_wr", 32'(exp_len + 1),
				32'(cyc - wr_cyc));
			else if (snap_seen) expect_equal("snap_valid spacing", 32'(exp_len),
				32'(cyc - last_snap));
			after_wr = 1'b0;
			snap_seen = 1'b1;
			last_snap = cyc;
		end
	end

	// spi byte capture in mode 0 with msb first.
	always @(posedge sclk or posedge cs_n) begin
		if (cs_n) begin
			expect_equal("spi bits at cs_n rise", 32'(0), 32'(nbits));
			nbits = 0;
			first_flag = 1'b1; // next byte opens a command.
		end else begin
			shreg = {shreg[6:0], sdin};
			nbits = nbits + 1;
			if (nbits == 8) begin
				bus_q.push_back({first_flag, dc, shreg});
				first_flag = 1'b0;
				nbits = 0;
			end
		end
	end

	////////////////////////////////////////
	// bus content checks.
	////////////////////////////////////////
	task automatic next_byte(output logic [9:0] b);
		while (rd_ptr >= bus_q.size()) @(posedge clk);
		b = bus_q[rd_ptr];
		rd_ptr = rd_ptr + 1;
	endtask

	// three address bytes and n data bytes in one cs_n frame.
	task automatic check_group(input int col, input int page, input int n, input logic zero);
		logic [9:0] b;
		int exp;
		for (int i = 0; i < 3; i++) begin
			next_byte(b);
			exp = (i == 0) ? col % 16 : (i == 1) ? 16 + col / 16 : 176 + page;
			expect_equal("address byte", 32'(exp), 32'(b[7:0]));
			expect_equal("address dc", 32'(0), 32'(b[8]));
			expect_equal("command start", 32'(i == 0), 32'(b[9]));
		end
		for (int i = 0; i < n; i++) begin
			next_byte(b);
			expect_equal("data dc", 32'(1), 32'(b[8]));
			expect_equal("command start", 32'(0), 32'(b[9])); // no early cs_n rise.
			if (zero) expect_equal("clear byte", 32'(0), 32'(b[7:0]));
		end
	endtask

	initial begin : bus_check
		logic [9:0] b;
		for (int i = 0; i < `OLED_INIT_LEN; i++) begin
			next_byte(b);
			expect_equal("init byte", 32'(`OLED_INIT_BYTE(i)), 32'(b[7:0]));
			expect_equal("init dc", 32'(0), 32'(b[8]));
			expect_equal("command start", 32'(i == 0), 32'(b[9]));
		end
		check_group(0, 0, CLEAR_BYTES, 1'b1); // whole gram.
		clear_done = 1'b1;
		forever begin
			for (int k = 0; k < NUM_DIGITS; k++) check_group(k * GLYPH_W, int'(DIGIT_PAGE),
				GLYPH_W, 1'b0);
			frames_seen = frames_seen + 1;
		end
	end

	initial begin
		#(WD_CYCLES * CLK_PERIOD);
		$display("simulation timed out");
		$display("Errors found");
		$fatal(1);
	end

	////////////////////////////////////////
	// main sequence.
	////////////////////////////////////////
	initial begin
		rst_n = 1'b0;
		pulse = 1'b0;
		cfg_wr = 1'b0;
		cfg_gate_len = '0;
		repeat (RESET_CYC) begin
			@(negedge clk);
			check_idle();
		end
		@(posedge clk);
		#10;
		rst_n = 1'b1;
		@(negedge clk);
		check_idle(); // first cycle out of reset.

		while (!clear_done) @(posedge clk);
		hold(1);
		write_gate(GATE_A);
		wait_snap(); // empty window.
		repeat (3) begin
			drive_burst(GATE_A - 20);
			wait_snap();
		end
		pulse = 1'b1; // one long pulse counts once.
		model_edges = model_edges + 1;
		hold(500);
		pulse = 1'b0;
		wait_snap();
		write_gate(GATE_B); // restart mid window.
		drive_burst(GATE_B - 20);
		wait_snap();

		while (frames_seen < FRAMES) @(posedge clk);
		hold(200);
		expect_equal("frames drawn", 32'(FRAMES), 32'(frames_seen));
		expect_equal("spi byte count", 32'(BUS_BYTES), 32'(bus_q.size()));
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
